//--- sim.f
logic/adc_pkg.sv
logic/adc_conv_ctrl.sv
logic/clk_sync.sv
logic/oversample_filter.sv
logic/adc_acq_top.sv
tb/adc_acq_tb.sv

//--- Bender.yml
package:
  name: adc_acq

sources:
  # synthesizable design, package first
  - target: rtl
    files:
      - logic/adc_pkg.sv
      - logic/adc_conv_ctrl.sv
      - logic/clk_sync.sv
      - logic/oversample_filter.sv
      - logic/adc_acq_top.sv

  # testbench, top module adc_acq_tb
  - target: test
    files:
      - logic/adc_pkg.sv
      - logic/adc_conv_ctrl.sv
      - logic/clk_sync.sv
      - logic/oversample_filter.sv
      - logic/adc_acq_top.sv
      - tb/adc_acq_tb.sv

//--- tb/adc_acq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module adc_acq_tb;

    import adc_pkg::*;

    ////////////////////////////////////////
    // constants
    ////////////////////////////////////////

    // model view of the dut defaults
    localparam int N_ADC     = 8;
    localparam int DV_CYCLES = 4;
    localparam int OVS_LOG2  = 2;
    localparam int HALF      = N_ADC / 2;
    localparam int RATIO     = 1 << OVS_LOG2;

    localparam int          PERIOD   = 20;
    localparam int          N_ROWS   = 32;
    localparam int          WAIT_MAX = 50;
    // observation window per conversion
    // busy already falls at t+9
    localparam int          WINDOW   = 14;
    localparam logic [15:0] SEED     = 16'd60920;
    localparam logic [W_DATA-1:0] ONES = '1;

    ////////////////////////////////////////
    // signals and state
    ////////////////////////////////////////

    logic              sys_clk_in;
    logic              reset_in;
    logic              conv_start;
    logic [W_DATA-1:0] raw_a;
    logic [W_DATA-1:0] raw_b;
    logic              busy;
    logic              result_valid;
    adc_result_t       result;

    // stimulus table of chip a and chip b words
    logic [W_DATA-1:0] tab_a [N_ROWS];
    logic [W_DATA-1:0] tab_b [N_ROWS];

    // reference model
    int sum [N_ADC];
    int cnt [N_ADC];
    int pair_idx;

    int          cyc;
    int          errors;
    int          checks;
    int          tests;
    int          n_results;
    int          n_expected;
    bit          timed_out;
    logic [15:0] lfsr;

    adc_acq_top DUT (
        .sys_clk_in   (sys_clk_in),
        .reset_in     (reset_in),
        .conv_start   (conv_start),
        .raw_a        (raw_a),
        .raw_b        (raw_b),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        sys_clk_in = 1'b0;
        forever #(PERIOD / 2) sys_clk_in = ~sys_clk_in;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // fixed rows cover the first block of every pair
    function automatic logic [2*W_DATA-1:0] fixed_row(input int row);
        logic [2*W_DATA-1:0] r;
        case (row)
            // pair 0 gets all ones on a and zeros on b
            0, 4, 8, 12: r = {ONES, 18'd0};
            // pair 2 mean lands just below full scale on a
            2, 6, 10:    r = {ONES, 18'd0};
            14:          r = {18'h3FFFE, 18'd1};
            // pair 1 small sums lose their fraction
            1:           r = {18'd1, 18'd3};
            5:           r = {18'd2, 18'd3};
            9:           r = {18'd0, 18'd3};
            13:          r = {18'd0, 18'd2};
            // pair 3 has midscale on b
            3:           r = {18'd5, 18'h20000};
            7:           r = {18'd6, 18'h20000};
            11:          r = {18'd7, 18'h20000};
            default:     r = {18'd9, 18'h20000};
        endcase
        return r;
    endfunction

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    task automatic draw_word(output logic [W_DATA-1:0] w);
        w = '0;
        for (int i = 0; i < W_DATA; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[W_DATA-2:0], lfsr[0]};
        end
    endtask

    // step to 2 ns past the next rising edge
    task automatic tick();
        @(posedge sys_clk_in);
        #2;
        cyc++;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("error at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    // one word into a channel and report a finished block
    task automatic model_word(input int ch, input logic [W_DATA-1:0] d,
                              output bit done, output int mean);
        sum[ch] += d;
        cnt[ch]++;
        done = (cnt[ch] == RATIO);
        mean = sum[ch] / RATIO;
        if (done) begin
            sum[ch] = 0;
            cnt[ch] = 0;
        end
    endtask

    task automatic wait_idle(output bit ok);
        int n;
        n = 0;
        while (busy !== 1'b0 && n < WAIT_MAX) begin
            tick();
            n++;
        end
        ok = (busy === 1'b0);
    endtask

    ////////////////////////////////////////
    // one table row
    ////////////////////////////////////////

    task automatic run_row(input int r);
        int t;
        int lat;
        int drop_off;
        int busy_cnt;
        int row_err;
        int chan_a;
        int chan_b;
        int mean_a;
        int mean_b;
        bit exp_a;
        bit exp_b;
        bit got_a;
        bit got_b;
        bit busy_done;
        row_err = errors;
        chan_a  = pair_idx;
        chan_b  = pair_idx + HALF;
        model_word(chan_a, tab_a[r], exp_a, mean_a);
        model_word(chan_b, tab_b[r], exp_b, mean_b);
        pair_idx   = (pair_idx + 1) % HALF;
        n_expected = n_expected + exp_a + exp_b;
        // stray start early in busy or on its very last cycle
        drop_off = (r % 3 == 1) ? 2 : ((r % 3 == 2) ? 2 * DV_CYCLES : 0);

        raw_a      = tab_a[r];
        raw_b      = tab_b[r];
        conv_start = 1'b1;
        tick();
        conv_start = 1'b0;
        t          = cyc;
        // chip outputs move on once the pair is latched
        raw_a      = ~tab_a[r];
        raw_b      = ~tab_b[r];
        check_val("busy", busy, 1);
        busy_cnt  = 1;
        busy_done = 1'b0;
        got_a     = 1'b0;
        got_b     = 1'b0;

        for (int i = 0; i < WINDOW; i++) begin
            tick();
            conv_start = 1'b0;
            if (drop_off != 0 && cyc == t + drop_off) begin
                conv_start = 1'b1;
            end
            if (!busy_done) begin
                if (busy) begin
                    busy_cnt++;
                end else begin
                    busy_done = 1'b1;
                end
            end else begin
                check_true(!busy, "busy rose again although no start was accepted");
            end
            if (result_valid) begin
                // value seen here is the one sampled at the next edge
                lat = cyc + 1 - t;
                n_results++;
                if (lat == 4) begin
                    check_true(exp_a && !got_a, "chip A result where none was due");
                    got_a = 1'b1;
                    check_val("result.chan", result.chan, chan_a);
                    check_val("result.mean", result.mean, mean_a);
                end else if (lat == 5) begin
                    check_true(exp_b && !got_b, "chip B result where none was due");
                    got_b = 1'b1;
                    check_val("result.chan", result.chan, chan_b);
                    check_val("result.mean", result.mean, mean_b);
                end else begin
                    check_true(1'b0, $sformatf("result_valid pulsed at latency %0d", lat));
                end
            end
        end
        conv_start = 1'b0;

        check_val("busy cycles", busy_cnt, 2 * DV_CYCLES + 1);
        check_true(got_a == exp_a, $sformatf("chip A result missing on row %0d", r));
        check_true(got_b == exp_b, $sformatf("chip B result missing on row %0d", r));
        tests++;
        $display("row %0d: chan %0d/%0d, results %0d, %s", r, chan_a, chan_b,
                 int'(got_a) + int'(got_b), (errors == row_err) ? "ok" : "with errors");
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        bit idle_ok;
        logic [W_DATA-1:0] w;
        reset_in   = 1'b1;
        conv_start = 1'b0;
        raw_a      = '0;
        raw_b      = '0;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        n_results  = 0;
        n_expected = 0;
        timed_out  = 1'b0;
        pair_idx   = 0;
        lfsr       = SEED;
        for (int c = 0; c < N_ADC; c++) begin
            sum[c] = 0;
            cnt[c] = 0;
        end

        // lower half fixed and upper half from the lfsr
        for (int r = 0; r < N_ROWS; r++) begin
            if (r < N_ROWS / 2) begin
                {tab_a[r], tab_b[r]} = fixed_row(r);
            end else begin
                draw_word(w);
                tab_a[r] = w;
                draw_word(w);
                tab_b[r] = w;
            end
        end

        repeat (5) tick();
        reset_in = 1'b0;

        // nothing may move while idle after reset
        for (int i = 0; i < 10; i++) begin
            tick();
            check_val("busy", busy, 0);
            check_val("result_valid", result_valid, 0);
        end
        tests++;
        $display("reset state: %s", (errors == 0) ? "ok" : "with errors");

        for (int r = 0; r < N_ROWS; r++) begin
            if (!timed_out) begin
                wait_idle(idle_ok);
                if (idle_ok) begin
                    run_row(r);
                end else begin
                    $display("timeout at %0d ns: busy stayed high before row %0d", $time, r);
                    timed_out = 1'b1;
                    errors++;
                end
            end
        end

        check_val("result count", n_results, n_expected);
        tests++;
        $display("result count: %0d of %0d", n_results, n_expected);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/adc_acq_top.sv
`timescale 1ns/10ps
`default_nettype none

module adc_acq_top #(
    parameter int N_ADC     = 8,
    parameter int DV_CYCLES = 4,
    parameter int OVS_LOG2  = 2
) (
    input  wire logic                       sys_clk_in,
    input  wire logic                       reset_in,

    // conversion request and chip outputs
    input  wire logic                       conv_start,
    input  wire logic [adc_pkg::W_DATA-1:0] raw_a,
    input  wire logic [adc_pkg::W_DATA-1:0] raw_b,

    // status and averaged results
    output logic                            busy,
    output logic                            result_valid,
    output adc_pkg::adc_result_t            result
);

    import adc_pkg::*;

    ////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////

    // controller to clk_sync, pair stable while dv high
    logic        dv;
    adc_pair_t   pair;

    // clk_sync to filter, one word per strobe
    logic        sample_valid;
    adc_sample_t sample;

    ////////////////////////////////////////
    // producer
    ////////////////////////////////////////

    adc_conv_ctrl #(
        .N_ADC     (N_ADC),
        .DV_CYCLES (DV_CYCLES)
    ) u_conv_ctrl (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .conv_start (conv_start),
        .raw_a      (raw_a),
        .raw_b      (raw_b),
        .busy       (busy),
        .dv         (dv),
        .pair       (pair)
    );

    ////////////////////////////////////////
    // buffer and serializer
    ////////////////////////////////////////

    clk_sync u_clk_sync (
        .sys_clk_in   (sys_clk_in),
        .reset_in     (reset_in),
        .dv           (dv),
        .pair         (pair),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    ////////////////////////////////////////
    // consumer
    ////////////////////////////////////////

    oversample_filter #(
        .N_ADC    (N_ADC),
        .OVS_LOG2 (OVS_LOG2)
    ) u_filter (
        .sys_clk_in   (sys_clk_in),
        .reset_in     (reset_in),
        .sample_valid (sample_valid),
        .sample       (sample),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- logic/oversample_filter.sv
`timescale 1ns/10ps
`default_nettype none

module oversample_filter #(
    parameter int N_ADC    = 8,
    parameter int OVS_LOG2 = 2
) (
    input  wire logic                 sys_clk_in,
    input  wire logic                 reset_in,

    // serialized words from clk_sync
    input  wire logic                 sample_valid,
    input  wire adc_pkg::adc_sample_t sample,

    // averaged output
    output logic                      result_valid,
    output adc_pkg::adc_result_t      result
);

    import adc_pkg::*;

    ////////////////////////////////////////
    // local parameters
    ////////////////////////////////////////

    // samples per block
    localparam int RATIO = 1 << OVS_LOG2;

    // accumulator sized so a full block of max words cannot overflow
    localparam int W_ACC = W_DATA + OVS_LOG2;

    // one spare bit keeps the counter legal when OVS_LOG2 is 0
    localparam int W_CNT = OVS_LOG2 + 1;

    ////////////////////////////////////////
    // per-channel state
    ////////////////////////////////////////

    logic [W_ACC-1:0] acc [N_ADC];
    logic [W_CNT-1:0] cnt [N_ADC];

    ////////////////////////////////////////
    // combinational update
    ////////////////////////////////////////

    logic [W_ACC-1:0] sum_next;
    logic             block_done;

    // running sum including the incoming word
    always_comb begin
        sum_next   = acc[sample.chan] + W_ACC'(sample.data);
        block_done = sample_valid && (cnt[sample.chan] == W_CNT'(RATIO - 1));
    end

    ////////////////////////////////////////
    // accumulators and counters
    ////////////////////////////////////////

    // channels interleave freely, each block runs on its own
    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            for (int i = 0; i < N_ADC; i++) begin
                acc[i] <= '0;
                cnt[i] <= '0;
            end
        end else if (sample_valid) begin
            if (block_done) begin
                // block complete, start fresh
                acc[sample.chan] <= '0;
                cnt[sample.chan] <= '0;
            end else begin
                acc[sample.chan] <= sum_next;
                cnt[sample.chan] <= cnt[sample.chan] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // result register
    ////////////////////////////////////////

    // strobe one cycle after the last sample of a block
    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= block_done;
        end
    end

    // mean by shift, fraction dropped
    always_ff @(posedge sys_clk_in) begin
        if (block_done) begin
            result.chan <= sample.chan;
            result.mean <= W_DATA'(sum_next >> OVS_LOG2);
        end
    end

endmodule

`default_nettype wire

//--- logic/clk_sync.sv
`timescale 1ns/10ps
`default_nettype none

module clk_sync (
    input  wire logic                sys_clk_in,
    input  wire logic                reset_in,

    // from conversion controller
    input  wire logic                dv,
    input  wire adc_pkg::adc_pair_t  pair,

    // to oversample filter
    output logic                     sample_valid,
    output adc_pkg::adc_sample_t     sample
);

    import adc_pkg::*;

    ////////////////////////////////////////
    // local parameters
    ////////////////////////////////////////

    // wait for valid high
    localparam logic [2:0] ST_WAIT_DVH = 3'd0;
    // pair captured, one settle cycle
    localparam logic [2:0] ST_HOLD     = 3'd1;
    // present chip a word
    localparam logic [2:0] ST_SEND_A   = 3'd2;
    // present chip b word
    localparam logic [2:0] ST_SEND_B   = 3'd3;
    // wait for valid low before rearming
    localparam logic [2:0] ST_WAIT_DVL = 3'd4;

    ////////////////////////////////////////
    // internal signals
    ////////////////////////////////////////

    logic [2:0] state;
    logic [2:0] next_state;

    // local copy of the pair
    adc_pair_t  pair_q;

    ////////////////////////////////////////
    // output decode
    ////////////////////////////////////////

    // word is zero outside the send states
    always_comb begin
        case (state)
            ST_SEND_A: begin
                sample_valid = 1'b1;
                sample.chan  = pair_q.chan_a;
                sample.data  = pair_q.data_a;
            end
            ST_SEND_B: begin
                sample_valid = 1'b1;
                sample.chan  = pair_q.chan_b;
                sample.data  = pair_q.data_b;
            end
            default: begin
                sample_valid = 1'b0;
                sample       = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // pair register
    ////////////////////////////////////////

    // load only on the first valid cycle
    always_ff @(posedge sys_clk_in) begin
        if (state == ST_WAIT_DVH && dv) begin
            pair_q <= pair;
        end
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////

    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            state <= ST_WAIT_DVH;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        case (state)
            ST_WAIT_DVH: begin
                if (dv) begin
                    next_state = ST_HOLD;
                end
            end
            ST_HOLD: begin
                next_state = ST_SEND_A;
            end
            ST_SEND_A: begin
                next_state = ST_SEND_B;
            end
            ST_SEND_B: begin
                next_state = ST_WAIT_DVL;
            end
            ST_WAIT_DVL: begin
                // one word pair per dv pulse
                if (!dv) begin
                    next_state = ST_WAIT_DVH;
                end
            end
            default: begin
                next_state = ST_WAIT_DVH;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/adc_conv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module adc_conv_ctrl #(
    parameter int N_ADC     = 8,
    parameter int DV_CYCLES = 4
) (
    input  wire logic                       sys_clk_in,
    input  wire logic                       reset_in,

    // conversion request and chip outputs
    input  wire logic                       conv_start,
    input  wire logic [adc_pkg::W_DATA-1:0] raw_a,
    input  wire logic [adc_pkg::W_DATA-1:0] raw_b,

    // status and slow-domain output
    output logic                            busy,
    output logic                            dv,
    output adc_pkg::adc_pair_t              pair
);

    import adc_pkg::*;

    ////////////////////////////////////////
    // local parameters
    ////////////////////////////////////////

    // chip a owns the lower half, chip b the upper half
    localparam int HALF = N_ADC / 2;

    // counter must reach DV_CYCLES in the low phase
    localparam int W_CNT = $clog2(DV_CYCLES + 1);

    // sequencer phases
    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_HIGH = 2'd1;
    localparam logic [1:0] PH_LOW  = 2'd2;

    ////////////////////////////////////////
    // internal signals
    ////////////////////////////////////////

    logic [1:0]        phase;
    logic [W_CNT-1:0]  cnt;
    logic [W_CHAN-1:0] pair_idx;
    logic              accept;

    // pulses while busy are simply dropped
    assign accept = conv_start & (phase == PH_IDLE);

    // status decoded from phase
    assign busy = (phase != PH_IDLE);
    assign dv   = (phase == PH_HIGH);

    ////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////

    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            phase    <= PH_IDLE;
            cnt      <= '0;
            pair_idx <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        phase <= PH_HIGH;
                        cnt   <= '0;
                        // step to next pair, wrap at half
                        if (pair_idx == W_CHAN'(HALF - 1)) begin
                            pair_idx <= '0;
                        end else begin
                            pair_idx <= pair_idx + 1'b1;
                        end
                    end
                end
                PH_HIGH: begin
                    // dv high for DV_CYCLES cycles
                    if (cnt == W_CNT'(DV_CYCLES - 1)) begin
                        phase <= PH_LOW;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PH_LOW: begin
                    // low stretch plus the final busy cycle, 2*DV_CYCLES+1 total
                    if (cnt == W_CNT'(DV_CYCLES)) begin
                        phase <= PH_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // result capture
    ////////////////////////////////////////

    // pair held steady while dv is up
    always_ff @(posedge sys_clk_in) begin
        if (accept) begin
            pair.chan_a <= pair_idx;
            pair.chan_b <= pair_idx + W_CHAN'(HALF);
            pair.data_a <= raw_a;
            pair.data_b <= raw_b;
        end
    end

endmodule

`default_nettype wire

//--- logic/adc_pkg.sv
`default_nettype none

package adc_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // adc word width, unsigned
    localparam int W_DATA = 18;

    // channel number width, covers up to 8 channels
    localparam int W_CHAN = 3;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // one conversion result from both chips
    typedef struct packed {
        logic [W_CHAN-1:0] chan_a;
        logic [W_CHAN-1:0] chan_b;
        logic [W_DATA-1:0] data_a;
        logic [W_DATA-1:0] data_b;
    } adc_pair_t;

    // one serialized word
    typedef struct packed {
        logic [W_CHAN-1:0] chan;
        logic [W_DATA-1:0] data;
    } adc_sample_t;

    // one filter output
    typedef struct packed {
        logic [W_CHAN-1:0] chan;
        // truncated block mean
        logic [W_DATA-1:0] mean;
    } adc_result_t;

endpackage

`default_nettype wire
